// File: common/mpu_pkg.sv
// Matrix processing unit shared definitions
// Matrix limits, element and index types, sequencer state encodings

`default_nettype none

package mpu_pkg;

    // ----------------------------------------
    // Matrix limits
    // ----------------------------------------
    localparam int M           = 4;     // Largest row count
    localparam int N           = 4;     // Largest column count
    localparam int MATRIX_REGS = 8;     // Number of matrix registers

    // ----------------------------------------
    // Data and index types
    // ----------------------------------------
    typedef logic [31:0] fp_elem_t;     // One floating point element, opaque
    typedef logic [2:0]  dim_t;         // Dimension 0..4, zero marks empty
    typedef logic [1:0]  idx_t;         // Row or column index
    typedef logic [2:0]  reg_addr_t;    // Matrix register address

    // ----------------------------------------
    // Sequencer states
    // ----------------------------------------
    typedef enum logic {
        LOAD_IDLE,
        LOAD_MATRIX
    } load_state_e;

    typedef enum logic {
        STORE_IDLE,
        STORE_READ
    } store_state_e;

endpackage : mpu_pkg

`default_nettype wire

// File: mpu_load/mpu_load.sv
// Matrix load sequencer
// Takes one element per cycle from the external source and writes it
// into a matrix register in row-major order, acknowledging each element

`timescale 1ns/1ps
`default_nettype none

module mpu_load (
    input  logic                clk,
    input  logic                rst,
    input  logic                load_en,
    input  mpu_pkg::reg_addr_t  load_addr,
    input  mpu_pkg::dim_t       load_m,
    input  mpu_pkg::dim_t       load_n,
    input  mpu_pkg::fp_elem_t   load_element,
    output logic                load_ack,
    output logic                load_error,
    output logic                wr_en,
    output mpu_pkg::reg_addr_t  wr_addr,
    output mpu_pkg::idx_t       wr_i,
    output mpu_pkg::idx_t       wr_j,
    output mpu_pkg::dim_t       wr_m,
    output mpu_pkg::dim_t       wr_n,
    output mpu_pkg::fp_elem_t   wr_element
);

    import mpu_pkg::*;

    load_state_e state_q, state_d;
    idx_t        row_q;                 // Current row pointer
    idx_t        col_q;                 // Current column pointer
    logic        row_end;
    logic        col_end;
    logic        last_elem;

    // ----------------------------------------
    // Dimension check and pass-through
    // ----------------------------------------
    assign load_error = (load_m == '0) || (load_m > dim_t'(M)) ||
                        (load_n == '0) || (load_n > dim_t'(N));

    assign wr_addr    = load_addr;
    assign wr_element = load_element;
    assign wr_m       = load_m;
    assign wr_n       = load_n;
    assign wr_i       = row_q;
    assign wr_j       = col_q;

    // One element written and acknowledged per cycle in LOAD_MATRIX
    assign wr_en    = (state_q == LOAD_MATRIX);
    assign load_ack = (state_q == LOAD_MATRIX);

    // End of transfer at (m-1, n-1)
    assign row_end   = ({1'b0, row_q} == load_m - 3'd1);
    assign col_end   = ({1'b0, col_q} == load_n - 3'd1);
    assign last_elem = row_end && col_end;

    // ----------------------------------------
    // State machine
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            LOAD_IDLE: begin
                if (load_en && !load_error) begin
                    state_d = LOAD_MATRIX;
                end
            end
            LOAD_MATRIX: begin
                if (last_elem) begin
                    state_d = LOAD_IDLE;    // Restart possible if enable still high
                end
            end
            default: state_d = LOAD_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= LOAD_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Row-major pointer walk, back to the origin after the last element
    always_ff @(posedge clk) begin
        if (rst) begin
            row_q <= '0;
            col_q <= '0;
        end else if (state_q == LOAD_MATRIX) begin
            if (last_elem) begin
                row_q <= '0;
                col_q <= '0;
            end else if (col_end) begin
                row_q <= row_q + 2'd1;  // Next row
                col_q <= '0;
            end else begin
                col_q <= col_q + 2'd1;
            end
        end
    end

    // Writes stay inside the dimensions held by the source
    a_wr_in_bounds : assert property (@(posedge clk) disable iff (rst)
        wr_en |-> ({1'b0, wr_i} < wr_m) && ({1'b0, wr_j} < wr_n));

endmodule : mpu_load

`default_nettype wire

// File: mpu_store/mpu_store.sv
// Matrix store sequencer
// Reads a matrix register back out row-major, one element per cycle,
// with a valid strobe, a last flag and an error pulse for empty registers

`timescale 1ns/1ps
`default_nettype none

module mpu_store (
    input  logic                clk,
    input  logic                rst,
    input  logic                store_en,
    input  mpu_pkg::reg_addr_t  store_addr,
    input  mpu_pkg::fp_elem_t   rd_element,
    input  mpu_pkg::dim_t       rd_m,
    input  mpu_pkg::dim_t       rd_n,
    output mpu_pkg::reg_addr_t  rd_addr,
    output mpu_pkg::idx_t       rd_i,
    output mpu_pkg::idx_t       rd_j,
    output logic                store_valid,
    output logic                store_last,
    output logic                store_error,
    output mpu_pkg::fp_elem_t   store_element,
    output mpu_pkg::idx_t       store_i,
    output mpu_pkg::idx_t       store_j
);

    import mpu_pkg::*;

    store_state_e state_q;
    reg_addr_t    addr_q;               // Register being read out
    dim_t         m_q;                  // Size captured at start
    dim_t         n_q;
    idx_t         row_q;
    idx_t         col_q;
    logic         start;
    logic         empty;
    logic         row_end;
    logic         col_end;
    logic         last_elem;

    // In idle, look up the requested register directly to test for empty
    assign rd_addr = (state_q == STORE_IDLE) ? store_addr : addr_q;
    assign rd_i    = row_q;
    assign rd_j    = col_q;

    assign start = (state_q == STORE_IDLE) && store_en;
    assign empty = (rd_m == '0);

    assign row_end   = ({1'b0, row_q} == m_q - 3'd1);
    assign col_end   = ({1'b0, col_q} == n_q - 3'd1);
    assign last_elem = row_end && col_end;

    // ----------------------------------------
    // Output stream
    // ----------------------------------------
    assign store_valid   = (state_q == STORE_READ);
    assign store_last    = (state_q == STORE_READ) && last_elem;
    assign store_element = rd_element;
    assign store_i       = row_q;
    assign store_j       = col_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= STORE_IDLE;
            store_error <= 1'b0;
            row_q       <= '0;
            col_q       <= '0;
        end else begin
            store_error <= start && empty;  // One-cycle pulse with no data sent
            case (state_q)
                STORE_IDLE: begin
                    if (start && !empty) begin
                        state_q <= STORE_READ;
                    end
                end
                STORE_READ: begin
                    if (last_elem) begin
                        state_q <= STORE_IDLE;
                        row_q   <= '0;
                        col_q   <= '0;
                    end else if (col_end) begin
                        row_q <= row_q + 2'd1;
                        col_q <= '0;
                    end else begin
                        col_q <= col_q + 2'd1;
                    end
                end
                default: state_q <= STORE_IDLE;
            endcase
        end
    end

    // Address and size latched when a read-out starts
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= store_addr;
            m_q    <= rd_m;
            n_q    <= rd_n;
        end
    end

    // Last element sits at the size still held by the register
    a_last_at_stored_size : assert property (@(posedge clk) disable iff (rst)
        store_last |-> store_valid && ({1'b0, store_i} == rd_m - 3'd1) &&
                       ({1'b0, store_j} == rd_n - 3'd1));

endmodule : mpu_store

`default_nettype wire

// File: rtl/matrix_reg_file.sv
// Matrix register file
// MATRIX_REGS matrices of up to M x N elements, each with its stored size.
// One write port, one combinational read port

`timescale 1ns/1ps
`default_nettype none

module matrix_reg_file (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_en,
    input  mpu_pkg::reg_addr_t  wr_addr,
    input  mpu_pkg::idx_t       wr_i,
    input  mpu_pkg::idx_t       wr_j,
    input  mpu_pkg::dim_t       wr_m,
    input  mpu_pkg::dim_t       wr_n,
    input  mpu_pkg::fp_elem_t   wr_element,
    input  mpu_pkg::reg_addr_t  rd_addr,
    input  mpu_pkg::idx_t       rd_i,
    input  mpu_pkg::idx_t       rd_j,
    output mpu_pkg::fp_elem_t   rd_element,
    output mpu_pkg::dim_t       rd_m,
    output mpu_pkg::dim_t       rd_n
);

    import mpu_pkg::*;

    fp_elem_t elem_mem [MATRIX_REGS][M][N];  // Element storage
    dim_t     m_mem    [MATRIX_REGS];         // Stored rows, zero when empty
    dim_t     n_mem    [MATRIX_REGS];         // Stored columns

    // ----------------------------------------
    // Write port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            elem_mem[wr_addr][wr_i][wr_j] <= wr_element;
        end
    end

    // Size follows every write, so a reload resizes the register
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < MATRIX_REGS; r++) begin
                m_mem[r] <= '0;
                n_mem[r] <= '0;
            end
        end else if (wr_en) begin
            m_mem[wr_addr] <= wr_m;
            n_mem[wr_addr] <= wr_n;
        end
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------
    assign rd_element = elem_mem[rd_addr][rd_i][rd_j];
    assign rd_m       = m_mem[rd_addr];
    assign rd_n       = n_mem[rd_addr];

endmodule : matrix_reg_file

`default_nettype wire

// File: rtl/mpu_top.sv
// Matrix processing unit load/store slice
// Load sequencer, matrix register file and store sequencer

`timescale 1ns/1ps
`default_nettype none

module mpu_top (
    input  logic                clk,
    input  logic                rst,
    // Load side
    input  logic                load_en,
    input  mpu_pkg::reg_addr_t  load_addr,
    input  mpu_pkg::dim_t       load_m,
    input  mpu_pkg::dim_t       load_n,
    input  mpu_pkg::fp_elem_t   load_element,
    output logic                load_ack,
    output logic                load_error,
    // Store side
    input  logic                store_en,
    input  mpu_pkg::reg_addr_t  store_addr,
    output logic                store_valid,
    output logic                store_last,
    output mpu_pkg::fp_elem_t   store_element,
    output mpu_pkg::idx_t       store_i,
    output mpu_pkg::idx_t       store_j,
    output logic                store_error
);

    import mpu_pkg::*;

    // Write port wires
    logic      wr_en;
    reg_addr_t wr_addr;
    idx_t      wr_i, wr_j;
    dim_t      wr_m, wr_n;
    fp_elem_t  wr_element;

    // Read port wires
    reg_addr_t rd_addr;
    idx_t      rd_i, rd_j;
    fp_elem_t  rd_element;
    dim_t      rd_m, rd_n;

    mpu_load u_load (
        .clk(clk), .rst(rst),
        .load_en(load_en), .load_addr(load_addr),
        .load_m(load_m), .load_n(load_n), .load_element(load_element),
        .load_ack(load_ack), .load_error(load_error),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_i(wr_i), .wr_j(wr_j),
        .wr_m(wr_m), .wr_n(wr_n), .wr_element(wr_element)
    );

    matrix_reg_file u_regs (
        .clk(clk), .rst(rst),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_i(wr_i), .wr_j(wr_j),
        .wr_m(wr_m), .wr_n(wr_n), .wr_element(wr_element),
        .rd_addr(rd_addr), .rd_i(rd_i), .rd_j(rd_j),
        .rd_element(rd_element), .rd_m(rd_m), .rd_n(rd_n)
    );

    mpu_store u_store (
        .clk(clk), .rst(rst),
        .store_en(store_en), .store_addr(store_addr),
        .rd_element(rd_element), .rd_m(rd_m), .rd_n(rd_n),
        .rd_addr(rd_addr), .rd_i(rd_i), .rd_j(rd_j),
        .store_valid(store_valid), .store_last(store_last),
        .store_error(store_error), .store_element(store_element),
        .store_i(store_i), .store_j(store_j)
    );

endmodule : mpu_top

`default_nettype wire

// File: verif/tb_mpu.sv
// Testbench for the matrix processing unit load/store slice
// Replays load and store commands from a data file and checks the store
// stream against a reference model of the matrix registers

`timescale 1ns/1ps
`default_nettype none

module tb_mpu;

    import mpu_pkg::*;

    localparam int MEM_WORDS  = 512;
    localparam int REC_CYCLES = 40;     // Cycle budget per record
    localparam int MARGIN     = 50;

    logic      clk;
    logic      rst;
    logic      load_en;
    reg_addr_t load_addr;
    dim_t      load_m;
    dim_t      load_n;
    fp_elem_t  load_element;
    logic      load_ack;
    logic      load_error;
    logic      store_en;
    reg_addr_t store_addr;
    logic      store_valid;
    logic      store_last;
    logic      store_error;
    fp_elem_t  store_element;
    idx_t      store_i;
    idx_t      store_j;

    logic [31:0] tdata [MEM_WORDS];
    fp_elem_t    model_elem [MATRIX_REGS][M][N];   // Expected register contents
    int          model_m [MATRIX_REGS];            // Zero while never loaded
    int          model_n [MATRIX_REGS];
    int          errors;
    int          checks;
    int          cycle_count;
    int          cycle_limit;

    always #20 clk = ~clk;

    mpu_top uut (
        .clk(clk), .rst(rst),
        .load_en(load_en), .load_addr(load_addr), .load_m(load_m), .load_n(load_n),
        .load_element(load_element), .load_ack(load_ack), .load_error(load_error),
        .store_en(store_en), .store_addr(store_addr),
        .store_valid(store_valid), .store_last(store_last),
        .store_element(store_element), .store_i(store_i), .store_j(store_j),
        .store_error(store_error)
    );

    // Watchdog
    always @(posedge clk) begin
        if (rst) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
        end
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, a transfer never finished", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Words taken by the record at ptr, zero at the end marker
    function automatic int record_len(input int ptr);
        int m;
        int n;
        if (ptr + 5 > MEM_WORDS) begin
            return 0;
        end
        m = int'(tdata[ptr + 2]);
        n = int'(tdata[ptr + 3]);
        case (tdata[ptr])
            32'd1:   return (tdata[ptr + 4] != 0) ? 5 : 5 + m * n;
            32'd2:   return 5;
            32'd3:   return 6 + m * n;
            default: return 0;
        endcase
    endfunction

    // ----------------------------------------
    // One load, one store, or both at once
    // ----------------------------------------
    task automatic transfer(input int rec, input bit ld, input reg_addr_t l_addr,
                            input dim_t l_m, input dim_t l_n, input bit l_err,
                            input int base, input bit st, input reg_addr_t s_addr,
                            input bit s_err);
        int    l_total;
        int    s_total;
        int    s_n;
        int    acks;
        int    done_cyc;
        int    cyc;
        int    idx;
        bit    finished;
        string tag;

        l_total  = int'(l_m) * int'(l_n);
        s_n      = model_n[s_addr];
        s_total  = s_err ? 0 : model_m[s_addr] * s_n;  // Snapshot before any update
        acks     = 0;
        done_cyc = l_err ? 9 : -1;      // Error loads hold the enable for 10 cycles
        cyc      = 0;
        finished = 1'b0;
        if (ld) begin
            load_en   = 1'b1;
            load_addr = l_addr;
            load_m    = l_m;
            load_n    = l_n;
            if (!l_err) begin
                load_element = tdata[base];
            end
        end
        if (st) begin
            store_en   = 1'b1;
            store_addr = s_addr;
        end
        while (!finished) begin
            @(negedge clk);
            tag = $sformatf("rec%0d cyc%0d", rec, cyc);
            if (ld) begin
                if (cyc == 0) begin
                    check({tag, " load_error"}, 32'(l_err), 32'(load_error));
                end
                if (done_cyc >= 0) begin
                    check({tag, " load_ack"}, 32'd0, 32'(load_ack));
                end else if (load_ack) begin
                    acks++;
                    if (acks == l_total) begin
                        done_cyc = cyc;
                    end
                end
            end
            if (st && cyc == 0) begin
                check({tag, " store_valid"}, 32'd0, 32'(store_valid));
            end else if (st) begin
                idx = cyc - 1;
                check({tag, " store_error"}, 32'(s_err && cyc == 1), 32'(store_error));
                check({tag, " store_valid"}, 32'(idx < s_total), 32'(store_valid));
                if (idx < s_total) begin
                    check({tag, " store_element"},
                          model_elem[s_addr][idx / s_n][idx % s_n], store_element);
                    check({tag, " store_i"}, idx / s_n, 32'(store_i));
                    check({tag, " store_j"}, idx % s_n, 32'(store_j));
                    check({tag, " store_last"}, 32'(idx == s_total - 1), 32'(store_last));
                end
            end
            finished = (!ld || (done_cyc >= 0 && cyc >= done_cyc + 2)) &&
                       (!st || cyc >= s_total + 2);
            @(posedge clk);
            #2;
            if (st && cyc == 0) begin
                store_en = 1'b0;
            end
            if (ld && done_cyc == cyc) begin
                load_en = 1'b0;         // Released after the last acknowledge
            end else if (ld && done_cyc < 0) begin
                load_element = tdata[base + acks];
            end
            cyc++;
        end
        if (ld && !l_err) begin
            for (int i = 0; i < int'(l_m); i++) begin
                for (int j = 0; j < int'(l_n); j++) begin
                    model_elem[l_addr][i][j] = tdata[base + i * int'(l_n) + j];
                end
            end
            model_m[l_addr] = int'(l_m);
            model_n[l_addr] = int'(l_n);
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int        ptr;
        int        rec;
        reg_addr_t a;
        reg_addr_t s;
        dim_t      m;
        dim_t      n;
        bit        err;

        clk          = 1'b0;
        rst          = 1'b1;
        load_en      = 1'b0;
        load_addr    = '0;
        load_m       = '0;
        load_n       = '0;
        load_element = '0;
        store_en     = 1'b0;
        store_addr   = '0;
        errors       = 0;
        checks       = 0;
        for (int r = 0; r < MATRIX_REGS; r++) begin
            model_m[r] = 0;
            model_n[r] = 0;
        end
        $readmemh("verif/mpu_testdata.txt", tdata);

        // Run limit from the number of records
        ptr = 0;
        rec = 0;
        while (record_len(ptr) > 0) begin
            rec++;
            ptr += record_len(ptr);
        end
        cycle_limit = rec * REC_CYCLES + MARGIN;

        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check("reset load_ack", 32'd0, 32'(load_ack));
        check("reset store_valid", 32'd0, 32'(store_valid));
        check("reset store_last", 32'd0, 32'(store_last));
        check("reset store_error", 32'd0, 32'(store_error));
        @(posedge clk);
        #2;

        ptr = 0;
        rec = 0;
        while (record_len(ptr) > 0) begin
            a   = tdata[ptr + 1][2:0];
            m   = tdata[ptr + 2][2:0];
            n   = tdata[ptr + 3][2:0];
            err = tdata[ptr + 4][0];
            s   = tdata[ptr + 5][2:0];
            case (tdata[ptr])
                32'd1:   transfer(rec, 1'b1, a, m, n, err, ptr + 5, 1'b0, 3'd0, 1'b0);
                32'd2:   transfer(rec, 1'b0, 3'd0, 3'd0, 3'd0, 1'b0, 0, 1'b1, a, err);
                default: transfer(rec, 1'b1, a, m, n, err, ptr + 6, 1'b1, s,
                                  model_m[s] == 0);
            endcase
            ptr += record_len(ptr);
            rec++;
        end

        $display("Summary: %0d records, %0d checks, %0d errors", rec, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_mpu

`default_nettype wire

// File: verif/mpu_testdata.txt
// op addr m n err [store_addr] elements, op 1 load, 2 store, 3 load plus store, 0 end
// Load elements follow row-major only when err is 0; op 3 stores from store_addr
2 3 0 0 1                               // Never-loaded register
1 0 2 3 0                               // 2x3 into r0
    3f800000 40000000 40400000
    40800000 40a00000 40c00000
2 0 0 0 0
1 1 4 4 0                               // Full 4x4 into r1
    41000000 41100000 41200000 41300000
    41400000 41500000 41600000 41700000
    41800000 41880000 41900000 41980000
    41a00000 41a80000 41b00000 41b80000
1 0 0 2 1                               // Zero rows rejected
1 0 5 1 1                               // Too many rows rejected
2 0 0 0 0                               // r0 keeps 2x3
1 2 3 0 1                               // Zero columns on empty r2
2 2 0 0 1
1 0 1 2 0                               // Reload r0 as 1x2
    bf800000 c0000000
2 0 0 0 0
1 1 4 7 1                               // Too many columns rejected
2 1 0 0 0
3 4 2 2 0 1                             // Load r4 while r1 is read out
    42000000 42100000 42200000 42300000
2 4 0 0 0
0

// File: tb.f
common/mpu_pkg.sv
mpu_load/mpu_load.sv
mpu_store/mpu_store.sv
rtl/matrix_reg_file.sv
rtl/mpu_top.sv
verif/tb_mpu.sv

// File: Makefile
# Verilator build and run for the MPU load/store slice

VERILATOR ?= verilator
TOP       ?= tb_mpu
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

# Pass only when the simulation output holds the pass message
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
